// File: aim_predictor/aim_predictor.sv
`default_nettype none

module aim_predictor (
    input  wire                                clk,
    input  wire                                reset,
    // execute side.
    input  wire bp_kind_pkg::branch_kind_e     kind_ex,
    input  wire  [bp_geom_pkg::gh_width-1:0]   pc_ex_gh_hashed,
    input  wire  [bp_geom_pkg::bh_width-1:0]   pc_ex_bh_hashed,
    input  wire                                taken_real,
    input  wire                                choice_real,
    // fetch side.
    input  wire bp_kind_pkg::branch_kind_e     kind_pdc,
    input  wire  [bp_geom_pkg::gh_width-1:0]   pc_gh_hashed,
    input  wire  [bp_geom_pkg::bh_width-1:0]   pc_bh_hashed,
    output logic                               taken_pdc
);
    import bp_kind_pkg::*;

    logic update_en;
    logic taken_b;
    logic taken_g;
    logic choice_b_g; // 0 bimodal, 1 gshare.
    logic taken_sel;

    assign update_en = (kind_ex == direct_jump) ||
                       (kind_ex == indirect_jump) ||
                       (kind_ex == other_jump);

    counter_pht bpht_b (
        .clk              (clk),
        .reset            (reset),
        .hashed_pc        (pc_bh_hashed),
        .taken_pdc        (taken_b),
        .hashed_pc_update (pc_ex_bh_hashed),
        .taken_real       (taken_real),
        .update_en        (update_en)
    );

    counter_pht gpht_g (
        .clk              (clk),
        .reset            (reset),
        .hashed_pc        (pc_gh_hashed),
        .taken_pdc        (taken_g),
        .hashed_pc_update (pc_ex_gh_hashed),
        .taken_real       (taken_real),
        .update_en        (update_en)
    );

    // chooser shares the gshare index.
    choice_pht cpht_b_g (
        .clk              (clk),
        .reset            (reset),
        .hashed_pc        (pc_gh_hashed),
        .choice_pdc       (choice_b_g),
        .hashed_pc_update (pc_ex_gh_hashed),
        .choice_real      (choice_real),
        .update_en        (update_en)
    );

    assign taken_sel = choice_b_g ? taken_g : taken_b;

    always_comb begin
        case (kind_pdc)
            not_jump:      taken_pdc = 1'b0;
            call,
            ret:           taken_pdc = 1'b1; // always redirect.
            direct_jump,
            indirect_jump,
            other_jump:    taken_pdc = taken_sel;
            default:       taken_pdc = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: aim_predictor/choice_pht.sv
`default_nettype none

module choice_pht (
    input  wire                                       clk,
    input  wire                                       reset,
    input  wire  [bp_geom_pkg::pht_index_width-1:0]   hashed_pc,
    output logic                                      choice_pdc,
    input  wire  [bp_geom_pkg::pht_index_width-1:0]   hashed_pc_update,
    input  wire                                       choice_real,
    input  wire                                       update_en
);
    import bp_kind_pkg::*;
    import bp_geom_pkg::*;

    ctr_e cpht [pht_depth];
    ctr_e rd_ctr;
    ctr_e upd_ctr;

    assign rd_ctr  = cpht[hashed_pc];
    assign upd_ctr = cpht[hashed_pc_update];

    // 0 picks bimodal, 1 picks gshare.
    assign choice_pdc = rd_ctr[1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < pht_depth; i++) begin
                cpht[i] <= weak_nt; // lean bimodal while gshare warms up.
            end
        end else if (update_en) begin
            cpht[hashed_pc_update] <= ctr_next(upd_ctr, choice_real);
        end
    end

endmodule

`default_nettype wire

// File: aim_predictor/counter_pht.sv
`default_nettype none

module counter_pht (
    input  wire                                       clk,
    input  wire                                       reset,
    input  wire  [bp_geom_pkg::pht_index_width-1:0]   hashed_pc,
    output logic                                      taken_pdc,
    input  wire  [bp_geom_pkg::pht_index_width-1:0]   hashed_pc_update,
    input  wire                                       taken_real,
    input  wire                                       update_en
);
    import bp_kind_pkg::*;
    import bp_geom_pkg::*;

    ctr_e pht [pht_depth];
    ctr_e rd_ctr;
    ctr_e upd_ctr;

    assign rd_ctr  = pht[hashed_pc];
    assign upd_ctr = pht[hashed_pc_update];

    assign taken_pdc = rd_ctr[1]; // weak_t and strong_t.

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < pht_depth; i++) begin
                pht[i] <= weak_nt;
            end
        end else if (update_en) begin
            pht[hashed_pc_update] <= ctr_next(upd_ctr, taken_real);
        end
    end

    // saturate at the top.
    no_wrap_up: assert property (
        @(posedge clk) disable iff (reset)
        update_en && taken_real && upd_ctr == strong_t
        |=> pht[$past(hashed_pc_update)] == strong_t
    );

    // and at the bottom.
    no_wrap_down: assert property (
        @(posedge clk) disable iff (reset)
        update_en && !taken_real && upd_ctr == strong_nt
        |=> pht[$past(hashed_pc_update)] == strong_nt
    );

endmodule

`default_nettype wire

// File: common/bp_geom_pkg.sv
`default_nettype none

package bp_geom_pkg;

    localparam int addr_width      = 30; // word address.
    localparam int gh_width        = 8;
    localparam int bh_width        = 8;
    localparam int lht_index_width = 6;
    localparam int lht_depth       = 1 << lht_index_width;

    // both direction tables share one geometry.
    localparam int pht_index_width = gh_width;
    localparam int pht_depth       = 1 << pht_index_width;

endpackage

`default_nettype wire

// File: common/bp_kind_pkg.sv
`default_nettype none

package bp_kind_pkg;

    typedef enum logic [2:0] {
        not_jump      = 3'd0,
        direct_jump   = 3'd1,
        call          = 3'd2,
        ret           = 3'd3,
        indirect_jump = 3'd4,
        other_jump    = 3'd5
    } branch_kind_e;

    // upper half of the range means taken, or gshare in the chooser.
    typedef enum logic [1:0] {
        strong_nt = 2'd0,
        weak_nt   = 2'd1,
        weak_t    = 2'd2,
        strong_t  = 2'd3
    } ctr_e;

    // one saturating step toward the resolved bit.
    function automatic ctr_e ctr_next(ctr_e c, logic up);
        ctr_e n;
        n = c;
        if (up && c != strong_t) begin
            n = ctr_e'(c + 2'd1);
        end else if (!up && c != strong_nt) begin
            n = ctr_e'(c - 2'd1);
        end
        return n;
    endfunction

endpackage

`default_nettype wire

// File: dv/tb_branch_predictor.sv
`default_nettype none

module tb_branch_predictor;
    timeunit 1ns;
    timeprecision 1ps;

    import bp_kind_pkg::*;
    import bp_geom_pkg::*;

    localparam int reset_cycles    = 10;
    localparam int reset_state_len = 50;
    localparam int bimodal_len     = 16;
    localparam int gshare_len      = 32;
    localparam int gating_len      = 200;
    localparam int probe_len       = 2;
    localparam int random_len      = 2000;
    localparam int cycle_limit     = reset_cycles + reset_state_len + bimodal_len + gshare_len
                                   + gating_len + probe_len + random_len + 100;

    // fixed probe branches, low six bits differ so local histories stay apart.
    localparam logic [addr_width-1:0] pc_b = 30'h0001_2345;
    localparam logic [addr_width-1:0] pc_g = 30'h0002_3456;

    logic                  clk;
    logic                  reset;
    logic [addr_width-1:0] pc;
    branch_kind_e          kind_pdc;
    logic                  taken_pdc;
    logic [addr_width-1:0] pc_ex;
    branch_kind_e          kind_ex;
    logic                  taken_real;
    logic                  choice_real;

    // reference state.
    logic [1:0]          bim_ctr [pht_depth];
    logic [1:0]          gsh_ctr [pht_depth];
    logic [1:0]          cho_ctr [pht_depth];
    logic [gh_width-1:0] ghr_m;
    logic [bh_width-1:0] lht_m [lht_depth];

    integer                seed;
    int                    errors = 0;
    int                    checks = 0;
    int                    cycle_count = 0;
    string                 test_name = "reset";
    logic [addr_width-1:0] p;
    logic [addr_width-1:0] pe;

    branch_predictor_top dut0 (
        .clk         (clk),
        .reset       (reset),
        .pc          (pc),
        .kind_pdc    (kind_pdc),
        .taken_pdc   (taken_pdc),
        .pc_ex       (pc_ex),
        .kind_ex     (kind_ex),
        .taken_real  (taken_real),
        .choice_real (choice_real)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Test failures found");
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $finish;
        end
    end

    function automatic logic [1:0] sat_step(logic [1:0] c, logic up);
        logic [1:0] n;
        n = c;
        if (up && c < 2'd3) n = c + 2'd1;
        if (!up && c > 2'd0) n = c - 2'd1;
        return n;
    endfunction

    function automatic logic is_cond(branch_kind_e k);
        return (k == direct_jump) || (k == indirect_jump) || (k == other_jump);
    endfunction

    function automatic logic expected_taken(logic [addr_width-1:0] a, branch_kind_e k);
        logic [gh_width-1:0] gi;
        logic [bh_width-1:0] bi;
        logic                res;
        gi  = a[gh_width-1:0] ^ ghr_m;
        bi  = a[bh_width-1:0] ^ lht_m[a[lht_index_width-1:0]];
        res = (k == call) || (k == ret);
        if (is_cond(k)) begin
            res = (cho_ctr[gi] >= 2'd2) ? (gsh_ctr[gi] >= 2'd2) : (bim_ctr[bi] >= 2'd2);
        end
        return res;
    endfunction

    task automatic reset_model();
        for (int i = 0; i < pht_depth; i++) begin
            bim_ctr[i] = 2'd1; // weak not taken.
            gsh_ctr[i] = 2'd1;
            cho_ctr[i] = 2'd1;
        end
        for (int i = 0; i < lht_depth; i++) lht_m[i] = '0;
        ghr_m = '0;
    endtask

    // applies the resolution present during the cycle that just ended.
    task automatic train_model();
        logic [lht_index_width-1:0] li;
        logic [gh_width-1:0]        gi;
        logic [bh_width-1:0]        bi;
        if (is_cond(kind_ex)) begin
            li = pc_ex[lht_index_width-1:0];
            gi = pc_ex[gh_width-1:0] ^ ghr_m;
            bi = pc_ex[bh_width-1:0] ^ lht_m[li];
            bim_ctr[bi] = sat_step(bim_ctr[bi], taken_real);
            gsh_ctr[gi] = sat_step(gsh_ctr[gi], taken_real);
            cho_ctr[gi] = sat_step(cho_ctr[gi], choice_real);
            ghr_m       = {ghr_m[gh_width-2:0], taken_real};
            lht_m[li]   = {lht_m[li][bh_width-2:0], taken_real};
        end
    endtask

    task automatic check_taken(logic exp);
        checks++;
        assert (taken_pdc === exp) else begin
            errors++;
            $display("FAILED %s: expected %0b, actual %0b", test_name, exp, taken_pdc);
        end
    endtask

    task automatic run_cycle(logic [addr_width-1:0] a, branch_kind_e k,
                             logic [addr_width-1:0] ae, branch_kind_e ke, logic t, logic c);
        @(posedge clk);
        train_model();
        pc          <= a;
        kind_pdc    <= k;
        pc_ex       <= ae;
        kind_ex     <= ke;
        taken_real  <= t;
        choice_real <= c;
        @(negedge clk); // output settled from this cycle's inputs.
        check_taken(expected_taken(pc, kind_pdc));
    endtask

    function automatic logic [addr_width-1:0] next_pc();
        logic [31:0] r;
        r = $random(seed);
        return r[addr_width-1:0];
    endfunction

    function automatic logic coin();
        logic [31:0] r;
        r = $random(seed);
        return r[0];
    endfunction

    function automatic branch_kind_e any_kind();
        int v;
        v = $unsigned($random(seed)) % 6;
        return branch_kind_e'(v);
    endfunction

    // kinds that must leave the tables alone.
    function automatic branch_kind_e quiet_kind();
        int v;
        v = $unsigned($random(seed)) % 3;
        return (v == 0) ? not_jump : ((v == 1) ? call : ret);
    endfunction

    initial begin
        seed        = 50;
        reset       = 1'b1;
        pc          = '0;
        kind_pdc    = not_jump;
        pc_ex       = '0;
        kind_ex     = not_jump;
        taken_real  = 1'b0;
        choice_real = 1'b0;
        reset_model();
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;

        test_name = "reset_state";
        repeat (reset_state_len) begin
            run_cycle(next_pc(), any_kind(), next_pc(), not_jump, coin(), coin());
            check_taken((kind_pdc == call) || (kind_pdc == ret)); // untrained tables.
        end

        test_name = "bimodal_train";
        repeat (bimodal_len) run_cycle(pc_b, direct_jump, pc_b, direct_jump, 1'b1, 1'b0);
        check_taken(1'b1);

        test_name = "gshare_chooser";
        for (int i = 0; i < gshare_len; i++) begin
            run_cycle(pc_g, indirect_jump, pc_g, indirect_jump, logic'(i % 2), 1'b1);
        end
        check_taken(1'b1); // last applied outcome was 0, so gshare expects taken.

        test_name = "kind_gating";
        for (int i = 0; i < gating_len; i++) begin
            p = (i % 3 == 0) ? pc_b : ((i % 3 == 1) ? pc_g : next_pc());
            run_cycle(p, any_kind(), next_pc(), quiet_kind(), coin(), coin());
        end
        run_cycle(pc_g, direct_jump, pc_g, not_jump, 1'b0, 1'b0);
        check_taken(1'b0); // gshare learned not taken after a 1.
        run_cycle(pc_b, other_jump, pc_b, ret, 1'b0, 1'b1);
        check_taken(1'b1);

        test_name = "random_mix";
        repeat (random_len) begin
            p  = next_pc();
            pe = coin() ? p : next_pc();
            run_cycle(p, any_kind(), pe, any_kind(), coin(), coin());
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
common/bp_kind_pkg.sv
common/bp_geom_pkg.sv
rtl/history_regs.sv
rtl/history_hash.sv
aim_predictor/counter_pht.sv
aim_predictor/choice_pht.sv
aim_predictor/aim_predictor.sv
rtl/branch_predictor_top.sv
dv/tb_branch_predictor.sv

// File: rtl/branch_predictor_top.sv
`default_nettype none

module branch_predictor_top (
    input  wire                                clk,
    input  wire                                reset,
    // fetch.
    input  wire  [bp_geom_pkg::addr_width-1:0] pc,
    input  wire bp_kind_pkg::branch_kind_e     kind_pdc,
    output logic                               taken_pdc,
    // execute.
    input  wire  [bp_geom_pkg::addr_width-1:0] pc_ex,
    input  wire bp_kind_pkg::branch_kind_e     kind_ex,
    input  wire                                taken_real,
    input  wire                                choice_real
);
    import bp_geom_pkg::*;

    logic [gh_width-1:0] ghr;
    logic [bh_width-1:0] local_hist;
    logic [bh_width-1:0] local_hist_ex;
    logic [gh_width-1:0] pc_gh_hashed;
    logic [bh_width-1:0] pc_bh_hashed;
    logic [gh_width-1:0] pc_ex_gh_hashed;
    logic [bh_width-1:0] pc_ex_bh_hashed;

    history_regs u_history_regs (
        .clk           (clk),
        .reset         (reset),
        .kind_ex       (kind_ex),
        .taken_real    (taken_real),
        .pc            (pc),
        .pc_ex         (pc_ex),
        .ghr           (ghr),
        .local_hist    (local_hist),
        .local_hist_ex (local_hist_ex)
    );

    history_hash u_history_hash (
        .pc              (pc),
        .pc_ex           (pc_ex),
        .ghr             (ghr),
        .local_hist      (local_hist),
        .local_hist_ex   (local_hist_ex),
        .pc_gh_hashed    (pc_gh_hashed),
        .pc_bh_hashed    (pc_bh_hashed),
        .pc_ex_gh_hashed (pc_ex_gh_hashed),
        .pc_ex_bh_hashed (pc_ex_bh_hashed)
    );

    aim_predictor u_aim_predictor (
        .clk             (clk),
        .reset           (reset),
        .kind_ex         (kind_ex),
        .pc_ex_gh_hashed (pc_ex_gh_hashed),
        .pc_ex_bh_hashed (pc_ex_bh_hashed),
        .taken_real      (taken_real),
        .choice_real     (choice_real),
        .kind_pdc        (kind_pdc),
        .pc_gh_hashed    (pc_gh_hashed),
        .pc_bh_hashed    (pc_bh_hashed),
        .taken_pdc       (taken_pdc)
    );

endmodule

`default_nettype wire

// File: rtl/history_hash.sv
`default_nettype none

module history_hash (
    input  wire  [bp_geom_pkg::addr_width-1:0] pc,
    input  wire  [bp_geom_pkg::addr_width-1:0] pc_ex,
    input  wire  [bp_geom_pkg::gh_width-1:0]   ghr,
    input  wire  [bp_geom_pkg::bh_width-1:0]   local_hist,
    input  wire  [bp_geom_pkg::bh_width-1:0]   local_hist_ex,
    output logic [bp_geom_pkg::gh_width-1:0]   pc_gh_hashed,
    output logic [bp_geom_pkg::bh_width-1:0]   pc_bh_hashed,
    output logic [bp_geom_pkg::gh_width-1:0]   pc_ex_gh_hashed,
    output logic [bp_geom_pkg::bh_width-1:0]   pc_ex_bh_hashed
);
    import bp_geom_pkg::*;

    logic [gh_width-1:0] pc_gh_bits;
    logic [bh_width-1:0] pc_bh_bits;
    logic [gh_width-1:0] pc_ex_gh_bits;
    logic [bh_width-1:0] pc_ex_bh_bits;

    // pc is a word address, low bits go in as they are.
    assign pc_gh_bits    = pc[gh_width-1:0];
    assign pc_bh_bits    = pc[bh_width-1:0];
    assign pc_ex_gh_bits = pc_ex[gh_width-1:0];
    assign pc_ex_bh_bits = pc_ex[bh_width-1:0];

    // fetch side.
    assign pc_gh_hashed = pc_gh_bits ^ ghr;
    assign pc_bh_hashed = pc_bh_bits ^ local_hist;

    // execute side uses the same ghr, so training lands where fetch looked.
    assign pc_ex_gh_hashed = pc_ex_gh_bits ^ ghr;
    assign pc_ex_bh_hashed = pc_ex_bh_bits ^ local_hist_ex;

endmodule

`default_nettype wire

// File: rtl/history_regs.sv
`default_nettype none

module history_regs (
    input  wire                                    clk,
    input  wire                                    reset,
    input  wire bp_kind_pkg::branch_kind_e         kind_ex,
    input  wire                                    taken_real,
    input  wire  [bp_geom_pkg::addr_width-1:0]     pc,
    input  wire  [bp_geom_pkg::addr_width-1:0]     pc_ex,
    output logic [bp_geom_pkg::gh_width-1:0]       ghr,
    output logic [bp_geom_pkg::bh_width-1:0]       local_hist,
    output logic [bp_geom_pkg::bh_width-1:0]       local_hist_ex
);
    import bp_kind_pkg::*;
    import bp_geom_pkg::*;

    logic [bh_width-1:0] lht [lht_depth]; // per-branch local history.

    logic [lht_index_width-1:0] lht_rd_idx;
    logic [lht_index_width-1:0] lht_ex_idx;
    logic                       update_en;

    assign lht_rd_idx = pc[lht_index_width-1:0];
    assign lht_ex_idx = pc_ex[lht_index_width-1:0];

    // only conditional kinds train.
    assign update_en = (kind_ex == direct_jump) ||
                       (kind_ex == indirect_jump) ||
                       (kind_ex == other_jump);

    // reads see the state before this cycle's update.
    assign local_hist    = lht[lht_rd_idx];
    assign local_hist_ex = lht[lht_ex_idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            ghr <= '0;
        end else if (update_en) begin
            ghr <= {ghr[gh_width-2:0], taken_real}; // newest outcome in bit 0.
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < lht_depth; i++) begin
                lht[i] <= '0;
            end
        end else if (update_en) begin
            lht[lht_ex_idx] <= {local_hist_ex[bh_width-2:0], taken_real};
        end
    end

    // execute stage must only send defined kinds.
    kind_ex_legal: assert property (
        @(posedge clk) disable iff (reset)
        kind_ex <= other_jump
    ) else $error("kind_ex out of range: %0d", kind_ex);

endmodule

`default_nettype wire
